/* hdl/conv_wr_pkg.sv */
`default_nettype none

package conv_wr_pkg;

	localparam int unsigned FEAT_W          = 16;
	localparam int unsigned FEATS_PER_BEAT  = 4;   // 16-bit features in one 64-bit beat
	localparam int unsigned DATA_W          = 64;
	localparam int unsigned ADDR_W          = 32;
	localparam int unsigned BTT_W           = 12;  // up to 2048 bytes per request
	localparam int unsigned MAX_BURST_LEN   = 16;  // beats
	localparam int unsigned OUTSTANDING     = 4;   // burst table entries, also bursts in flight
	localparam int unsigned WBUF_DEPTH      = 32;  // must hold at least one full burst
	localparam int unsigned LANE_FIFO_DEPTH = 3;
	localparam int unsigned BEATS_W         = BTT_W - 2; // beat count minus one of a request
	localparam int unsigned PAGE_BEATS_W    = 9;   // 512 beats of 8 bytes per 4 KB page

	typedef struct packed {
		logic [ADDR_W-1:0] addr; // byte address, 2-byte aligned
		logic [BTT_W-1:0]  btt;  // byte count
	} wr_req_t;

	// feature lanes 0..3 inside a beat
	typedef struct packed {
		logic [1:0] first; // lane of first feature of the request
		logic [1:0] last;  // lane of last feature
	} lane_info_t;

	typedef struct packed {
		logic [ADDR_W-1:0] addr;
		logic [7:0]        len;  // beats minus one, AXI awlen
	} burst_t;

	typedef struct packed {
		logic [DATA_W-1:0]   data;
		logic [DATA_W/8-1:0] strb;
		logic                last; // last beat of a burst
	} wbeat_t;

	typedef enum logic [1:0] {
		WAIT_SLOT,
		GEN_LEN,
		COMMIT
	} plan_state_e;

	typedef enum logic [1:0] {
		FREE,
		PLANNED,
		DATA_READY
	} entry_state_e;

endpackage

`default_nettype wire

/* hdl/wr_req_intake.sv */
`default_nettype none

module wr_req_intake (
	input  wire                      clk,
	input  wire                      rst_n,
	input  wire conv_wr_pkg::wr_req_t req_i,
	input  wire                      req_valid_i,
	output logic                     req_ready_o,
	output conv_wr_pkg::wr_req_t     plan_req_o,
	output logic                     plan_valid_o,
	input  wire                      plan_ready_i,
	output conv_wr_pkg::lane_info_t  lane_o,
	output logic                     lane_valid_o,
	input  wire                      lane_ready_i
);
	import conv_wr_pkg::*;

	lane_info_t lane_mem [LANE_FIFO_DEPTH]; // lane queue storage
	lane_info_t lane_d;
	logic [$clog2(LANE_FIFO_DEPTH)-1:0] wr_ptr, rd_ptr;
	logic [$clog2(LANE_FIFO_DEPTH+1)-1:0] cnt;
	logic [2:0] end_off; // low bits of the last feature's byte address
	logic room, push, pop;

	assign room = cnt != LANE_FIFO_DEPTH;
	assign plan_valid_o = req_valid_i & room; // request passes straight on to the planner
	assign plan_req_o = req_i;
	assign req_ready_o = plan_ready_i & room;
	assign push = req_valid_i & req_ready_o;
	assign pop = lane_valid_o & lane_ready_i;

	assign end_off = req_i.addr[2:0] + req_i.btt[2:0] - 3'd2; // addr + btt - 2
	assign lane_d.first = req_i.addr[2:1];
	assign lane_d.last = end_off[2:1];

	assign lane_valid_o = cnt != '0;
	assign lane_o = lane_mem[rd_ptr];

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			cnt <= '0;
		end
		else
		begin
			if (push)
				wr_ptr <= (wr_ptr == LANE_FIFO_DEPTH - 1) ? '0 : wr_ptr + 1'b1; // depth 3, explicit wrap
			if (pop)
				rd_ptr <= (rd_ptr == LANE_FIFO_DEPTH - 1) ? '0 : rd_ptr + 1'b1;
			if (push && !pop)
				cnt <= cnt + 1'b1;
			else if (!push && pop)
				cnt <= cnt - 1'b1;
		end
	end

	always_ff @(posedge clk)
	begin
		if (push)
			lane_mem[wr_ptr] <= lane_d;
	end

endmodule

`default_nettype wire

/* hdl/aw_burst_planner.sv */
`default_nettype none

module aw_burst_planner (
	input  wire                          clk,
	input  wire                          rst_n,
	input  wire conv_wr_pkg::wr_req_t    req_i,
	input  wire                          req_valid_i,
	output logic                         req_ready_o,
	output logic [7:0]                   blen_o,
	output logic                         blen_valid_o,
	input  wire                          blen_ready_i,
	input  wire                          burst_data_done_i,
	output logic [conv_wr_pkg::ADDR_W-1:0] awaddr_o,
	output logic [7:0]                   awlen_o,
	output logic                         awvalid_o,
	input  wire                          awready_i,
	input  wire                          slot_free_i,
	output logic                         launch_o,
	output logic                         launch_last_o
);
	import conv_wr_pkg::*;

	plan_state_e state;
	logic busy; // request in progress
	logic [ADDR_W-1:0] cur_addr;         // 8-byte aligned address of next burst
	logic [BEATS_W-1:0] rem_m1;          // beats left in request minus one
	logic [PAGE_BEATS_W-1:0] page_m1;    // beats left in 4 KB page minus one
	logic [7:0] len_m1;                  // min result, becomes awlen
	logic last_burst;
	logic [BTT_W:0] end_off;
	logic [BEATS_W-1:0] cmp_a, cmp_b;
	logic cmp_le;
	logic req_fire, slot_go, commit, prep_fire, aw_fire;

	burst_t tbl [OUTSTANDING];
	entry_state_e ent [OUTSTANDING];
	logic [$clog2(OUTSTANDING)-1:0] wr_ptr, prep_ptr, disp_ptr; // power-of-2 depth, free wrap

	assign req_ready_o = (state == WAIT_SLOT) & ~busy;
	assign req_fire = req_valid_i & req_ready_o;
	// offset in first beat + btt - 1, its upper bits are the beat count minus one
	assign end_off = {1'b0, req_i.btt} + {{(BTT_W-2){1'b0}}, req_i.addr[2:0]} - 1'b1;

	assign slot_go = (state == WAIT_SLOT) & busy & slot_free_i;
	assign commit = (state == COMMIT) & (ent[wr_ptr] == FREE);

	// shared compare-and-select
	// WAIT_SLOT: page beats vs max burst, GEN_LEN: request beats vs that result
	assign cmp_a = (state == WAIT_SLOT) ? BEATS_W'(page_m1) : rem_m1;
	assign cmp_b = (state == WAIT_SLOT) ? BEATS_W'(MAX_BURST_LEN - 1) : BEATS_W'(len_m1);
	assign cmp_le = cmp_a <= cmp_b;

	assign launch_o = commit;
	assign launch_last_o = last_burst;

	assign blen_o = tbl[prep_ptr].len;
	assign blen_valid_o = ent[prep_ptr] == PLANNED;
	assign prep_fire = blen_valid_o & blen_ready_i & burst_data_done_i; // all beats in packer stage

	assign awaddr_o = tbl[disp_ptr].addr;
	assign awlen_o = tbl[disp_ptr].len;
	assign awvalid_o = ent[disp_ptr] == DATA_READY; // address only once data is buffered
	assign aw_fire = awvalid_o & awready_i;

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state <= WAIT_SLOT;
			busy <= 1'b0;
		end
		else
		begin
			if (req_fire)
				busy <= 1'b1;
			else if (commit && last_burst)
				busy <= 1'b0;
			case (state)
				WAIT_SLOT: if (slot_go) state <= GEN_LEN;
				GEN_LEN:   state <= COMMIT;
				COMMIT:    if (commit) state <= WAIT_SLOT; // hold while entry busy
				default:   state <= WAIT_SLOT;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (req_fire)
		begin
			cur_addr <= {req_i.addr[ADDR_W-1:3], 3'b000};
			rem_m1 <= end_off[BTT_W:3];
			page_m1 <= ~req_i.addr[11:3]; // 511 - beat index in page
		end
		else if (commit)
		begin
			cur_addr <= cur_addr + ((ADDR_W'(len_m1) + 1'b1) << 3);
			rem_m1 <= rem_m1 - BEATS_W'(len_m1) - 1'b1;
			page_m1 <= page_m1 - PAGE_BEATS_W'(len_m1) - 1'b1; // wraps to 511 on a page cross
		end
		if (slot_go || state == GEN_LEN)
			len_m1 <= cmp_le ? cmp_a[7:0] : cmp_b[7:0];
		if (state == GEN_LEN)
			last_burst <= cmp_le; // remaining beats fit in this burst
		if (commit)
		begin
			tbl[wr_ptr].addr <= cur_addr;
			tbl[wr_ptr].len <= len_m1;
		end
	end

	// entries move FREE -> PLANNED -> DATA_READY -> FREE, each step on its own pointer
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			for (int i = 0; i < OUTSTANDING; i++)
				ent[i] <= FREE;
			wr_ptr <= '0;
			prep_ptr <= '0;
			disp_ptr <= '0;
		end
		else
		begin
			if (commit)
			begin
				ent[wr_ptr] <= PLANNED;
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (prep_fire)
			begin
				ent[prep_ptr] <= DATA_READY;
				prep_ptr <= prep_ptr + 1'b1;
			end
			if (aw_fire)
			begin
				ent[disp_ptr] <= FREE;
				disp_ptr <= disp_ptr + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

/* hdl/feature_packer.sv */
`default_nettype none

module feature_packer (
	input  wire                            clk,
	input  wire                            rst_n,
	input  wire [conv_wr_pkg::FEAT_W-1:0]  feat_i,
	input  wire                            feat_last_i,
	input  wire                            feat_valid_i,
	output logic                           feat_ready_o,
	input  wire conv_wr_pkg::lane_info_t   lane_i,
	input  wire                            lane_valid_i,
	output logic                           lane_ready_o,
	input  wire [7:0]                      blen_i,
	input  wire                            blen_valid_i,
	output logic                           blen_ready_o,
	output logic                           burst_data_done_o,
	output conv_wr_pkg::wbeat_t            beat_o,
	output logic                           beat_valid_o,
	input  wire                            beat_ready_i
);
	import conv_wr_pkg::*;

	logic [FEAT_W-1:0] lane_data [FEATS_PER_BEAT]; // features of the beat being built
	logic [1:0] lane_q;   // lane of next feature
	logic [1:0] cur_lane;
	logic first_feat;     // next feature starts a request
	logic first_beat;     // beat being built is the request's first
	logic [7:0] beat_cnt; // beats of current burst already loaded
	logic closing, s0_ready, feat_fire, beat_load, burst_last;
	wbeat_t beat_d;

	assign cur_lane = first_feat ? lane_i.first : lane_q;
	assign closing = (cur_lane == 2'(FEATS_PER_BEAT - 1)) | feat_last_i;
	assign s0_ready = ~beat_valid_o | beat_ready_i; // output stage free or draining

	// need lane info and a planned burst before taking features
	assign feat_ready_o = lane_valid_i & blen_valid_i & (~closing | s0_ready);
	assign feat_fire = feat_valid_i & feat_ready_o;
	assign beat_load = feat_fire & closing;
	assign burst_last = beat_cnt == blen_i;

	assign lane_ready_o = feat_fire & feat_last_i; // pop on the request's last feature
	assign blen_ready_o = s0_ready;
	assign burst_data_done_o = beat_load & burst_last;

	always_comb
	begin
		beat_d.last = burst_last;
		for (int l = 0; l < FEATS_PER_BEAT; l++)
		begin
			beat_d.data[l*FEAT_W +: FEAT_W] = (l == cur_lane) ? feat_i : lane_data[l];
			// two strobe bits per lane, cut below first lane and above last lane
			beat_d.strb[l*(FEAT_W/8) +: FEAT_W/8] = {(FEAT_W/8){
				(!first_beat || l >= lane_i.first) && (!feat_last_i || l <= lane_i.last)}};
		end
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			first_feat <= 1'b1;
			first_beat <= 1'b1;
			lane_q <= '0;
			beat_cnt <= '0;
			beat_valid_o <= 1'b0;
		end
		else
		begin
			if (feat_fire)
			begin
				first_feat <= feat_last_i;
				lane_q <= cur_lane + 1'b1; // wraps to lane 0 after lane 3
			end
			if (beat_load)
			begin
				first_beat <= feat_last_i;
				beat_cnt <= burst_last ? '0 : beat_cnt + 1'b1;
			end
			if (s0_ready)
				beat_valid_o <= beat_load;
		end
	end

	always_ff @(posedge clk)
	begin
		if (feat_fire)
			lane_data[cur_lane] <= feat_i;
		if (beat_load)
			beat_o <= beat_d; // output register
	end

endmodule

`default_nettype wire

/* hdl/wdata_buffer.sv */
`default_nettype none

module wdata_buffer (
	input  wire                             clk,
	input  wire                             rst_n,
	input  wire conv_wr_pkg::wbeat_t        beat_i,
	input  wire                             beat_valid_i,
	output logic                            beat_ready_o,
	output logic [conv_wr_pkg::DATA_W-1:0]  wdata_o,
	output logic [conv_wr_pkg::DATA_W/8-1:0] wstrb_o,
	output logic                            wlast_o,
	output logic                            wvalid_o,
	input  wire                             wready_i
);
	import conv_wr_pkg::*;

	wbeat_t mem [WBUF_DEPTH];
	logic [$clog2(WBUF_DEPTH)-1:0] wr_ptr, rd_ptr; // power of 2, free wrap
	logic [$clog2(WBUF_DEPTH+1)-1:0] cnt;
	logic push, pop;

	assign beat_ready_o = cnt != WBUF_DEPTH;
	assign push = beat_valid_i & beat_ready_o;
	assign pop = wvalid_o & wready_i;

	// fall-through, head entry drives W directly
	assign wvalid_o = cnt != '0;
	assign wdata_o = mem[rd_ptr].data;
	assign wstrb_o = mem[rd_ptr].strb;
	assign wlast_o = mem[rd_ptr].last;

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			cnt <= '0;
		end
		else
		begin
			if (push)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			if (push && !pop)
				cnt <= cnt + 1'b1;
			else if (!push && pop)
				cnt <= cnt - 1'b1;
		end
	end

	always_ff @(posedge clk)
	begin
		if (push)
			mem[wr_ptr] <= beat_i;
	end

endmodule

`default_nettype wire

/* hdl/bresp_tracker.sv */
`default_nettype none

module bresp_tracker (
	input  wire  clk,
	input  wire  rst_n,
	input  wire  launch_i,
	input  wire  launch_last_i,
	input  wire  bvalid_i,
	output logic slot_free_o,
	output logic done_o
);
	import conv_wr_pkg::*;

	logic last_flag [OUTSTANDING]; // per burst in flight, closes a request
	logic [$clog2(OUTSTANDING)-1:0] wr_ptr, rd_ptr;
	logic [$clog2(OUTSTANDING+1)-1:0] cnt; // bursts launched, no B yet

	assign slot_free_o = cnt < OUTSTANDING;
	// responses come back in launch order
	assign done_o = bvalid_i & last_flag[rd_ptr];

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			cnt <= '0;
		end
		else
		begin
			if (launch_i)
				wr_ptr <= wr_ptr + 1'b1;
			if (bvalid_i)
				rd_ptr <= rd_ptr + 1'b1;
			if (launch_i && !bvalid_i)
				cnt <= cnt + 1'b1;
			else if (!launch_i && bvalid_i)
				cnt <= cnt - 1'b1;
		end
	end

	always_ff @(posedge clk)
	begin
		if (launch_i)
			last_flag[wr_ptr] <= launch_last_i;
	end

endmodule

`default_nettype wire

/* hdl/conv_out_axi_wr.sv */
`default_nettype none

module conv_out_axi_wr (
	input  wire                              clk,
	input  wire                              rst_n,
	input  wire conv_wr_pkg::wr_req_t        req_i,
	input  wire                              req_valid_i,
	output logic                             req_ready_o,
	input  wire [conv_wr_pkg::FEAT_W-1:0]    feat_i,
	input  wire                              feat_last_i,
	input  wire                              feat_valid_i,
	output logic                             feat_ready_o,
	output logic [conv_wr_pkg::ADDR_W-1:0]   awaddr_o,
	output logic [7:0]                       awlen_o,
	output logic                             awvalid_o,
	input  wire                              awready_i,
	output logic [conv_wr_pkg::DATA_W-1:0]   wdata_o,
	output logic [conv_wr_pkg::DATA_W/8-1:0] wstrb_o,
	output logic                             wlast_o,
	output logic                             wvalid_o,
	input  wire                              wready_i,
	input  wire                              bvalid_i,
	output logic                             done_o
);
	import conv_wr_pkg::*;

	wr_req_t plan_req;        // intake to planner
	logic plan_valid, plan_ready;
	lane_info_t lane;         // head of lane queue
	logic lane_valid, lane_ready;
	logic [7:0] blen;         // oldest planned burst length
	logic blen_valid, blen_ready, burst_data_done;
	wbeat_t beat;
	logic beat_valid, beat_ready;
	logic slot_free, launch, launch_last;

	wr_req_intake wr_req_intake_inst (
		.clk          (clk),
		.rst_n        (rst_n),
		.req_i        (req_i),
		.req_valid_i  (req_valid_i),
		.req_ready_o  (req_ready_o),
		.plan_req_o   (plan_req),
		.plan_valid_o (plan_valid),
		.plan_ready_i (plan_ready),
		.lane_o       (lane),
		.lane_valid_o (lane_valid),
		.lane_ready_i (lane_ready)
	);

	aw_burst_planner aw_burst_planner_inst (
		.clk               (clk),
		.rst_n             (rst_n),
		.req_i             (plan_req),
		.req_valid_i       (plan_valid),
		.req_ready_o       (plan_ready),
		.blen_o            (blen),
		.blen_valid_o      (blen_valid),
		.blen_ready_i      (blen_ready),
		.burst_data_done_i (burst_data_done),
		.awaddr_o          (awaddr_o),
		.awlen_o           (awlen_o),
		.awvalid_o         (awvalid_o),
		.awready_i         (awready_i),
		.slot_free_i       (slot_free),
		.launch_o          (launch),
		.launch_last_o     (launch_last)
	);

	feature_packer feature_packer_inst (
		.clk               (clk),
		.rst_n             (rst_n),
		.feat_i            (feat_i),
		.feat_last_i       (feat_last_i),
		.feat_valid_i      (feat_valid_i),
		.feat_ready_o      (feat_ready_o),
		.lane_i            (lane),
		.lane_valid_i      (lane_valid),
		.lane_ready_o      (lane_ready),
		.blen_i            (blen),
		.blen_valid_i      (blen_valid),
		.blen_ready_o      (blen_ready),
		.burst_data_done_o (burst_data_done),
		.beat_o            (beat),
		.beat_valid_o      (beat_valid),
		.beat_ready_i      (beat_ready)
	);

	wdata_buffer wdata_buffer_inst (
		.clk          (clk),
		.rst_n        (rst_n),
		.beat_i       (beat),
		.beat_valid_i (beat_valid),
		.beat_ready_o (beat_ready),
		.wdata_o      (wdata_o),
		.wstrb_o      (wstrb_o),
		.wlast_o      (wlast_o),
		.wvalid_o     (wvalid_o),
		.wready_i     (wready_i)
	);

	bresp_tracker bresp_tracker_inst (
		.clk           (clk),
		.rst_n         (rst_n),
		.launch_i      (launch),
		.launch_last_i (launch_last),
		.bvalid_i      (bvalid_i),
		.slot_free_o   (slot_free),
		.done_o        (done_o)
	);

endmodule

`default_nettype wire

/* sim/tb_conv_out_axi_wr.sv */
`default_nettype none

module tb_conv_out_axi_wr;
	timeunit 1ns;
	timeprecision 1ps;
	import conv_wr_pkg::*;

	logic clk;
	logic rst_n;
	wr_req_t req;
	logic req_valid, req_ready;
	logic [FEAT_W-1:0] feat;
	logic feat_last, feat_valid, feat_ready;
	logic [ADDR_W-1:0] awaddr;
	logic [7:0] awlen;
	logic awvalid, awready;
	logic [DATA_W-1:0] wdata;
	logic [DATA_W/8-1:0] wstrb;
	logic wlast, wvalid, wready;
	logic bvalid, done;

	// front entry of each stimulus queue is on the bus
	wr_req_t req_q [$];
	logic [FEAT_W:0] feat_q [$]; // {last, feature}

	// reference model output
	burst_t burst_q [$];
	logic burst_last_q [$];      // burst closes its request
	wbeat_t beat_q [$];
	logic b_last_q [$];          // last flags of dispatched bursts in AW order

	int aw_cnt = 0;      // AW handshakes seen
	int wl_cnt = 0;      // W bursts completed
	int b_cnt = 0;       // B responses given
	int beats_seen = 0;
	int done_cnt = 0;
	int req_cnt = 0;
	int errors = 0;
	int aw_hold = 0;     // stall cycles left on awready
	int w_hold = 0;
	logic req_fire = 1'b0;
	logic feat_fire = 1'b0;
	logic timed_out = 1'b0;
	string test_name = "reset";

	burst_t eb;
	logic el;
	wbeat_t ew;
	logic [DATA_W-1:0] mask;

	conv_out_axi_wr conv_out_axi_wr_inst (
		.clk          (clk),
		.rst_n        (rst_n),
		.req_i        (req),
		.req_valid_i  (req_valid),
		.req_ready_o  (req_ready),
		.feat_i       (feat),
		.feat_last_i  (feat_last),
		.feat_valid_i (feat_valid),
		.feat_ready_o (feat_ready),
		.awaddr_o     (awaddr),
		.awlen_o      (awlen),
		.awvalid_o    (awvalid),
		.awready_i    (awready),
		.wdata_o      (wdata),
		.wstrb_o      (wstrb),
		.wlast_o      (wlast),
		.wvalid_o     (wvalid),
		.wready_i     (wready),
		.bvalid_i     (bvalid),
		.done_o       (done)
	);

	initial
	begin
		clk = 1'b0;
		forever #4 clk = ~clk; // 8 ns period
	end

	task automatic report_mismatch(input string what, input logic [DATA_W-1:0] exp,
		input logic [DATA_W-1:0] act);
		errors++;
		$display("FAIL %s %s: expected %h, actual %h", test_name, what, exp, act);
	endtask

	task automatic report_error(input string msg);
		errors++;
		$display("ERROR %s: %s", test_name, msg);
	endtask

	// expected bursts, beats and features of one request
	task automatic add_request(input logic [ADDR_W-1:0] addr, input int btt);
		wr_req_t r;
		wbeat_t bt [];
		burst_t bu;
		logic [FEAT_W-1:0] f;
		logic [ADDR_W-1:0] cur;
		int off, nb, pos, left, len, page_left;
		r.addr = addr;
		r.btt = btt[BTT_W-1:0];
		req_q.push_back(r);
		req_cnt++;
		off = addr[2:0];
		nb = (off + btt - 1) / 8 + 1; // beats touched by the byte range
		bt = new[nb];
		foreach (bt[k])
			bt[k] = '0;
		for (int i = 0; i < btt / 2; i++)
		begin
			f = FEAT_W'($urandom);
			feat_q.push_back({(i == btt / 2 - 1), f});
			pos = off / 2 + i; // feature slot from the aligned start
			bt[pos / 4].data[(pos % 4) * FEAT_W +: FEAT_W] = f;
			bt[pos / 4].strb[(pos % 4) * 2 +: 2] = 2'b11;
		end
		cur = {addr[ADDR_W-1:3], 3'b000};
		left = nb;
		pos = 0;
		while (left > 0)
		begin
			page_left = (4096 - int'(cur[11:0])) / 8; // beats up to the 4 KB boundary
			len = (left < page_left) ? left : page_left;
			if (len > MAX_BURST_LEN)
				len = MAX_BURST_LEN;
			bu.addr = cur;
			bu.len = 8'(len - 1);
			burst_q.push_back(bu);
			burst_last_q.push_back(left == len);
			pos += len;
			bt[pos - 1].last = 1'b1;
			cur = cur + ADDR_W'(len * 8);
			left -= len;
		end
		foreach (bt[k])
			beat_q.push_back(bt[k]);
	endtask

	function automatic bit pending_work();
		return req_q.size() != 0 || feat_q.size() != 0 || burst_q.size() != 0
			|| beat_q.size() != 0 || b_last_q.size() != 0 || done_cnt != req_cnt;
	endfunction

	task automatic wait_idle(input int max_cycles);
		int n;
		n = 0;
		while (!timed_out && pending_work() && n < max_cycles)
		begin
			@(negedge clk);
			n++;
		end
		if (!timed_out && pending_work())
		begin
			timed_out = 1'b1;
			report_error("timeout, the DUT did not finish its requests");
		end
	endtask

	task automatic start_test(input string name);
		@(posedge clk); // queues change away from the negedge drivers
		test_name = name;
	endtask

	// request payload held until accepted
	always @(negedge clk)
	begin
		if (req_fire)
			void'(req_q.pop_front());
		req_valid = req_q.size() != 0;
		if (req_q.size() != 0)
			req = req_q[0];
	end

	// feature stream with random gaps
	always @(negedge clk)
	begin
		if (feat_fire)
		begin
			void'(feat_q.pop_front());
			feat_valid = 1'b0;
		end
		if (!feat_valid && feat_q.size() != 0 && $urandom_range(3) != 0)
			feat_valid = 1'b1;
		if (feat_q.size() != 0)
			{feat_last, feat} = feat_q[0];
	end

	// AXI slave with random stall runs on AW and W and one B per finished burst
	always @(negedge clk)
	begin
		if (aw_hold > 0)
			aw_hold--;
		else if ($urandom_range(7) == 0)
			aw_hold = $urandom_range(12, 1);
		awready = aw_hold == 0;
		if (w_hold > 0)
			w_hold--;
		else if ($urandom_range(7) == 0)
			w_hold = $urandom_range(12, 1);
		wready = w_hold == 0;
		// a burst is answerable once both its AW and its wlast beat arrived
		bvalid = ((aw_cnt < wl_cnt ? aw_cnt : wl_cnt) > b_cnt) && $urandom_range(2) != 0;
	end

	// monitor samples 1 ns before the rising edge when everything is settled
	always @(negedge clk)
	begin
		#3;
		req_fire = req_valid & req_ready;
		feat_fire = feat_valid & feat_ready;
		if (rst_n)
		begin
			if (awvalid && awready)
			begin
				if (burst_q.size() == 0)
					report_error("AW burst issued with no burst expected");
				else
				begin
					eb = burst_q.pop_front();
					el = burst_last_q.pop_front();
					if (awaddr !== eb.addr)
						report_mismatch("awaddr", eb.addr, awaddr);
					if (awlen !== eb.len)
						report_mismatch("awlen", eb.len, awlen);
					b_last_q.push_back(el);
				end
				aw_cnt++;
			end
			if (wvalid && wready)
			begin
				if (beat_q.size() == 0)
					report_error("W beat sent with no beat expected");
				else
				begin
					ew = beat_q.pop_front();
					for (int i = 0; i < DATA_W / 8; i++)
						mask[i*8 +: 8] = {8{ew.strb[i]}}; // only strobed bytes carry data
					if (wstrb !== ew.strb)
						report_mismatch("wstrb", ew.strb, wstrb);
					if ((wdata & mask) !== (ew.data & mask))
						report_mismatch("wdata", ew.data & mask, wdata & mask);
					if (wlast !== ew.last)
						report_mismatch("wlast", ew.last, wlast);
				end
				beats_seen++;
				if (wlast)
					wl_cnt++;
			end
			if (bvalid)
			begin
				if (b_last_q.size() == 0)
					report_error("B response given with no burst dispatched");
				else
				begin
					el = b_last_q.pop_front();
					if (done !== el)
						report_mismatch("done_o", el, done);
				end
				b_cnt++;
			end
			else if (done !== 1'b0)
				report_mismatch("done_o", 0, done);
			if (done === 1'b1)
				done_cnt++;
		end
	end

	initial
	begin
		void'($urandom(32'h925502a7));
		rst_n = 1'b0;
		req = '0;
		req_valid = 1'b0;
		feat = '0;
		feat_last = 1'b0;
		feat_valid = 1'b0;
		awready = 1'b0;
		wready = 1'b0;
		bvalid = 1'b0;
		repeat (2) @(negedge clk);
		rst_n = 1'b1;
		#3;
		// idle outputs straight after reset
		if (req_ready !== 1'b1)
			report_mismatch("req_ready_o", 1, req_ready);
		if (awvalid !== 1'b0)
			report_mismatch("awvalid_o", 0, awvalid);
		if (wvalid !== 1'b0)
			report_mismatch("wvalid_o", 0, wvalid);
		if (done !== 1'b0)
			report_mismatch("done_o", 0, done);
		if (feat_ready !== 1'b0)
			report_mismatch("feat_ready_o", 0, feat_ready);

		start_test("aligned_64");
		add_request(32'h0000_2000, 64); // one burst with awlen 7
		wait_idle(4000);

		start_test("burst_split");
		add_request(32'h0001_0040, 256); // two bursts of 16 beats
		add_request(32'h0000_2FD0, 128); // 48 bytes below a page end
		wait_idle(8000);

		start_test("partial_strobe");
		add_request(32'h0000_4002, 18); // last lane 1
		add_request(32'h0000_5004, 40); // last lane 1
		add_request(32'h0000_6006, 46); // last lane 1
		wait_idle(8000);

		start_test("random_backpressure");
		for (int i = 0; i < 20; i++)
			add_request($urandom & 32'h00FF_FFFE, 2 * $urandom_range(256, 1));
		wait_idle(100000);

		$display("errors: %0d  requests: %0d  bursts: %0d  beats: %0d  done pulses: %0d",
			errors, req_cnt, aw_cnt, beats_seen, done_cnt);
		if (errors == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

endmodule

`default_nettype wire

/* list.f */
hdl/conv_wr_pkg.sv
hdl/wr_req_intake.sv
hdl/aw_burst_planner.sv
hdl/feature_packer.sv
hdl/wdata_buffer.sv
hdl/bresp_tracker.sv
hdl/conv_out_axi_wr.sv
sim/tb_conv_out_axi_wr.sv

/* Bender.yml */
package:
  name: conv_out_axi_wr

sources:
  - hdl/conv_wr_pkg.sv
  - hdl/wr_req_intake.sv
  - hdl/aw_burst_planner.sv
  - hdl/feature_packer.sv
  - hdl/wdata_buffer.sv
  - hdl/bresp_tracker.sv
  - hdl/conv_out_axi_wr.sv
  - target: simulation
    files:
      - sim/tb_conv_out_axi_wr.sv
